// File: hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // Major opcodes handled by the core, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LB    = 6'h20,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_SW    = 6'h2B
    } opcode_t;

    // R-type function codes, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_t;

    // I-type immediate, bits 15:0
    typedef logic [15:0] imm_t;

    // J-type word index, bits 25:0
    typedef logic [25:0] index_t;

    // Shift amount, bits 10:6
    typedef logic [4:0] shamt_t;

endpackage

`default_nettype wire

// File: hw/mips_core_pkg.sv
`default_nettype none

package mips_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;

    // One instruction in flight, bus transfers in FETCH and MEM_ACCESS only
    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_ACCESS,
        HALTED
    } cpu_state_t;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_LINK
    } alu_op_t;

    localparam reg_idx_t REG_V0 = 5'd2;
    localparam reg_idx_t REG_RA = 5'd31;

endpackage

`default_nettype wire

// File: hw/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control
    import mips_core_pkg::*;
    import mips_isa_pkg::*;
#(
    parameter word_t RESET_VECTOR = 32'hBFC00000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       waitrequest,
    input  word_t      readdata,
    input  logic       is_mem,
    input  logic       take_jump,
    input  word_t      jump_target,
    input  word_t      mem_addr,
    output word_t      instr,
    output word_t      pc,
    output cpu_state_t state,
    output logic       exec_stb,
    output logic       mem_done,
    output logic       active,
    output word_t      address,
    output logic       read,
    output logic       write
);

    word_t   ir;
    logic    booting;
    logic    delay_pending;
    word_t   delay_target;
    word_t   next_pc;
    opcode_t op;
    logic    is_store;

    assign instr    = ir;
    assign op       = opcode_t'(ir[31:26]);
    assign is_store = (op == OP_SW);

    // Delay slot done, so the stored target replaces the sequential pc
    assign next_pc = delay_pending ? delay_target : pc + 32'd4;

    assign exec_stb = (state == EXEC);
    assign mem_done = (state == MEM_ACCESS) && !waitrequest;
    assign active   = (state != HALTED);

    assign address = (state == MEM_ACCESS) ? mem_addr : pc;
    assign read    = (state == FETCH) || ((state == MEM_ACCESS) && !is_store);
    assign write   = (state == MEM_ACCESS) && is_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= HALTED;
            booting       <= 1'b1;
            pc            <= RESET_VECTOR;
            ir            <= '0;
            delay_pending <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (!waitrequest) begin
                        ir    <= readdata;
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    pc            <= next_pc;
                    delay_pending <= take_jump;
                    if (take_jump) begin
                        delay_target <= jump_target;
                    end
                    if (is_mem) begin
                        state <= MEM_ACCESS;
                    end else begin
                        state <= (next_pc == '0) ? HALTED : FETCH;
                    end
                end
                MEM_ACCESS: begin
                    if (!waitrequest) begin
                        // Retire the access so the next fetch sees all byte lanes
                        ir    <= '0;
                        state <= (pc == '0) ? HALTED : FETCH;
                    end
                end
                default: begin
                    // Leave reset through HALTED once, then stay until the next reset
                    if (booting) begin
                        booting <= 1'b0;
                        state   <= (pc == '0) ? HALTED : FETCH;
                    end
                end
            endcase
        end
    end

    // Jumps inside a delay slot are not supported
    a_no_nested_jump: assert property (@(posedge clk) disable iff (reset)
        exec_stb && delay_pending |-> !take_jump)
        else $error("cpu_control: jump in delay slot at pc %h", pc);

    a_bus_hold: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write))
        else $error("cpu_control: bus request changed under waitrequest");

endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
    import mips_core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    v0
);

    word_t regs [32];

    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];
    assign v0      = regs[REG_V0];

    // Register 0 is never written, so it reads as zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Write strobes come from control, which must be idle once reset has been seen
    a_no_write_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !wr_en)
        else $error("register_file: write to r%0d during reset", wr_idx);

endmodule

`default_nettype wire

// File: hw/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import mips_core_pkg::*;
    import mips_isa_pkg::*;
(
    input  word_t    instr,
    input  word_t    pc,
    input  word_t    rs_data,
    input  word_t    rt_data,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    output logic     alu_we,
    output reg_idx_t alu_dest,
    output word_t    alu_result,
    output logic     take_jump,
    output word_t    jump_target,
    output logic     is_mem
);

    opcode_t  op;
    funct_t   fn;
    reg_idx_t rd;
    shamt_t   shamt;
    imm_t     imm;
    index_t   index;
    alu_op_t  alu_op;
    word_t    imm_sext;
    word_t    operand_b;
    word_t    pc_plus4;

    assign op       = opcode_t'(instr[31:26]);
    assign fn       = funct_t'(instr[5:0]);
    assign rs_idx   = instr[25:21];
    assign rt_idx   = instr[20:16];
    assign rd       = instr[15:11];
    assign shamt    = instr[10:6];
    assign imm      = instr[15:0];
    assign index    = instr[25:0];
    assign imm_sext = {{16{imm[15]}}, imm};
    assign pc_plus4 = pc + 32'd4;

    // Logical immediates are zero-extended, the rest sign-extended
    assign operand_b = (op == OP_RTYPE) ? rt_data :
                       (op == OP_ANDI || op == OP_ORI || op == OP_XORI) ? {16'h0000, imm} :
                       imm_sext;

    assign alu_we = (alu_op != ALU_NOP);

    always_comb begin
        alu_op      = ALU_NOP;
        alu_dest    = (op == OP_RTYPE) ? rd : rt_idx;
        take_jump   = 1'b0;
        jump_target = pc_plus4 + {imm_sext[29:0], 2'b00};
        is_mem      = 1'b0;
        case (op)
            OP_RTYPE: begin
                case (fn)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    FN_JR: begin
                        take_jump   = 1'b1;
                        jump_target = rs_data;
                    end
                    default: alu_op = ALU_NOP;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_SLTI:  alu_op = ALU_SLT;
            OP_ANDI:  alu_op = ALU_AND;
            OP_ORI:   alu_op = ALU_OR;
            OP_XORI:  alu_op = ALU_XOR;
            OP_LUI:   alu_op = ALU_LUI;
            OP_BEQ:   take_jump = (rs_data == rt_data);
            OP_BNE:   take_jump = (rs_data != rt_data);
            OP_J, OP_JAL: begin
                take_jump   = 1'b1;
                jump_target = {pc_plus4[31:28], index, 2'b00};
                if (op == OP_JAL) begin
                    alu_op   = ALU_LINK;
                    alu_dest = REG_RA;
                end
            end
            OP_LW, OP_LB, OP_LBU, OP_SW: is_mem = 1'b1;
            default: alu_op = ALU_NOP;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = rs_data + operand_b;
            ALU_SUB:  alu_result = rs_data - operand_b;
            ALU_AND:  alu_result = rs_data & operand_b;
            ALU_OR:   alu_result = rs_data | operand_b;
            ALU_XOR:  alu_result = rs_data ^ operand_b;
            ALU_SLT:  alu_result = {31'd0, $signed(rs_data) < $signed(operand_b)};
            ALU_SLTU: alu_result = {31'd0, rs_data < operand_b};
            ALU_SLL:  alu_result = rt_data << shamt;
            ALU_SRL:  alu_result = rt_data >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(rt_data) >>> shamt);
            ALU_LUI:  alu_result = {imm, 16'h0000};
            // Return address skips the delay slot
            ALU_LINK: alu_result = pc + 32'd8;
            default:  alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
    import mips_core_pkg::*;
    import mips_isa_pkg::*;
(
    input  word_t    instr,
    input  word_t    rs_data,
    input  word_t    rt_data,
    input  word_t    readdata,
    output word_t    mem_addr,
    output byte_en_t byteenable,
    output word_t    writedata,
    output logic     load_we,
    output reg_idx_t load_dest,
    output word_t    load_data
);

    opcode_t    op;
    imm_t       imm;
    word_t      eff_addr;
    logic [1:0] lane;
    logic       byte_op;
    logic       word_op;
    logic [7:0] load_byte;

    assign op       = opcode_t'(instr[31:26]);
    assign imm      = instr[15:0];
    assign eff_addr = rs_data + {{16{imm[15]}}, imm};
    assign lane     = eff_addr[1:0];
    assign byte_op  = (op == OP_LB) || (op == OP_LBU);
    assign word_op  = (op == OP_LW) || (op == OP_SW);

    // Bus carries word addresses only, lanes pick the byte
    assign mem_addr  = {eff_addr[31:2], 2'b00};
    assign writedata = rt_data;
    assign load_we   = byte_op || (op == OP_LW);
    assign load_dest = instr[20:16];

    always_comb begin
        if (byte_op) begin
            case (lane)
                2'd0:    byteenable = 4'b0001;
                2'd1:    byteenable = 4'b0010;
                2'd2:    byteenable = 4'b0100;
                default: byteenable = 4'b1000;
            endcase
        end else begin
            byteenable = 4'b1111;
        end
    end

    always_comb begin
        case (lane)
            2'd0:    load_byte = readdata[7:0];
            2'd1:    load_byte = readdata[15:8];
            2'd2:    load_byte = readdata[23:16];
            default: load_byte = readdata[31:24];
        endcase
    end

    always_comb begin
        case (op)
            OP_LB:   load_data = {{24{load_byte[7]}}, load_byte};
            OP_LBU:  load_data = {24'h000000, load_byte};
            default: load_data = readdata;
        endcase
    end

    // Word accesses have no lane merge, so the low bits must already be clear
    always_comb begin
        if (word_op) begin
            a_word_aligned: assert (lane == 2'b00)
                else $error("load_store_unit: unaligned word access at %h", eff_addr);
        end
    end

endmodule

`default_nettype wire

// File: hw/mips_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus
    import mips_core_pkg::*;
#(
    parameter word_t RESET_VECTOR = 32'hBFC00000
) (
    input  logic     clk,
    input  logic     reset,
    output logic     active,
    output word_t    register_v0,

    // Avalon-MM master
    output word_t    address,
    output logic     write,
    output logic     read,
    input  logic     waitrequest,
    output word_t    writedata,
    output byte_en_t byteenable,
    input  word_t    readdata
);

    word_t      instr;
    word_t      pc;
    cpu_state_t state;
    logic       exec_stb;
    logic       mem_done;
    logic       is_mem;
    logic       take_jump;
    word_t      jump_target;
    word_t      mem_addr;

    reg_idx_t   rs_idx;
    reg_idx_t   rt_idx;
    word_t      rs_data;
    word_t      rt_data;

    logic       alu_we;
    reg_idx_t   alu_dest;
    word_t      alu_result;
    logic       load_we;
    reg_idx_t   load_dest;
    word_t      load_data;

    logic       wr_en;
    reg_idx_t   wr_idx;
    word_t      wr_data;

    // Single write port, ALU results at the end of EXEC, load data when the read completes
    assign wr_en   = (exec_stb && alu_we) || (mem_done && load_we);
    assign wr_idx  = (state == MEM_ACCESS) ? load_dest : alu_dest;
    assign wr_data = (state == MEM_ACCESS) ? load_data : alu_result;

    cpu_control #(
        .RESET_VECTOR(RESET_VECTOR)
    ) u_control (
        .clk(clk), .reset(reset), .waitrequest(waitrequest), .readdata(readdata),
        .is_mem(is_mem), .take_jump(take_jump), .jump_target(jump_target),
        .mem_addr(mem_addr), .instr(instr), .pc(pc), .state(state),
        .exec_stb(exec_stb), .mem_done(mem_done), .active(active),
        .address(address), .read(read), .write(write)
    );

    register_file u_regs (
        .clk(clk), .reset(reset), .rs_idx(rs_idx), .rt_idx(rt_idx),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .rs_data(rs_data), .rt_data(rt_data), .v0(register_v0)
    );

    alu_unit u_alu (
        .instr(instr), .pc(pc), .rs_data(rs_data), .rt_data(rt_data),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .alu_we(alu_we), .alu_dest(alu_dest),
        .alu_result(alu_result), .take_jump(take_jump), .jump_target(jump_target),
        .is_mem(is_mem)
    );

    load_store_unit u_lsu (
        .instr(instr), .rs_data(rs_data), .rt_data(rt_data), .readdata(readdata),
        .mem_addr(mem_addr), .byteenable(byteenable), .writedata(writedata),
        .load_we(load_we), .load_dest(load_dest), .load_data(load_data)
    );

endmodule

`default_nettype wire

// File: test/avalon_memory.sv
`timescale 1ns/1ps
`default_nettype none

module avalon_memory
    import mips_core_pkg::*;
    import mips_isa_pkg::*;
#(
    parameter word_t PROG_BASE = 32'hBFC00000,
    parameter word_t DATA_BASE = 32'h00001000
) (
    input  logic     clk,
    input  logic     reset,
    input  word_t    address,
    input  logic     read,
    input  logic     write,
    input  word_t    writedata,
    input  byte_en_t byteenable,
    output logic     waitrequest,
    output word_t    readdata
);

    localparam reg_idx_t ZERO = 5'd0;
    localparam reg_idx_t V0   = 5'd2;
    localparam reg_idx_t T0   = 5'd8;
    localparam reg_idx_t T1   = 5'd9;
    localparam reg_idx_t T2   = 5'd10;
    localparam reg_idx_t T3   = 5'd11;
    localparam reg_idx_t T4   = 5'd12;
    localparam reg_idx_t T5   = 5'd13;
    localparam reg_idx_t T6   = 5'd14;
    localparam reg_idx_t T7   = 5'd15;
    localparam reg_idx_t S0   = 5'd16;
    localparam reg_idx_t S1   = 5'd17;
    localparam reg_idx_t S2   = 5'd18;
    localparam reg_idx_t S3   = 5'd19;
    localparam reg_idx_t S4   = 5'd20;
    localparam reg_idx_t RA   = 5'd31;

    word_t  prog [32];
    word_t  data [16];
    integer seed = 23184;
    logic   in_prog;
    logic   in_data;

    assign in_prog = (address >= PROG_BASE) && (address < PROG_BASE + 32'd128);
    assign in_data = (address >= DATA_BASE) && (address < DATA_BASE + 32'd64);

    function automatic word_t rtype(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                    shamt_t sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jtype(opcode_t op, word_t target);
        return {op, target[27:2]};
    endfunction

    initial begin
        waitrequest = 1'b1;
        readdata    = '0;
        for (int i = 0; i < 32; i++) begin
            prog[i] = '0;
        end
        // Data fill is a function of the full byte address
        for (int i = 0; i < 16; i++) begin
            data[i] = (DATA_BASE + 32'(4 * i)) ^ 32'h5A5A5A5A;
        end
        prog[0]  = itype(OP_LUI, ZERO, T0, 16'h1234);
        prog[1]  = itype(OP_ORI, T0, T0, 16'h5678);
        prog[2]  = itype(OP_ADDIU, ZERO, T1, 16'd5);
        prog[3]  = itype(OP_ADDIU, ZERO, T2, 16'd7);
        // 5 - 7 is negative, so SLT against 5 gives 1
        prog[4]  = rtype(FN_SUBU, T1, T2, T3, 5'd0);
        prog[5]  = rtype(FN_SLT, T3, T1, S0, 5'd0);
        prog[6]  = itype(OP_ADDIU, ZERO, T4, 16'h1000);
        prog[7]  = itype(OP_SW, T4, T0, 16'd0);
        prog[8]  = itype(OP_LB, T4, S1, 16'd3);
        prog[9]  = itype(OP_LBU, T4, S2, 16'd3);
        prog[10] = itype(OP_LW, T4, S3, 16'd0);
        // Taken to offset 0x38, the delay slot counts and 0x34 is skipped
        prog[11] = itype(OP_BNE, S0, ZERO, 16'd2);
        prog[12] = itype(OP_ADDIU, S4, S4, 16'd1);
        prog[13] = itype(OP_ADDIU, S4, S4, 16'h0100);
        // A wrongly taken BEQ would skip the v0 setup at 0x40
        prog[14] = itype(OP_BEQ, S0, ZERO, 16'd2);
        prog[16] = rtype(FN_ADDU, S0, S2, V0, 5'd0);
        prog[17] = jtype(OP_JAL, PROG_BASE + 32'h60);
        prog[18] = rtype(FN_ADDU, V0, S4, V0, 5'd0);
        prog[19] = rtype(FN_ADDU, V0, S3, V0, 5'd0);
        // Return to address zero halts the core
        prog[20] = rtype(FN_JR, ZERO, ZERO, ZERO, 5'd0);
        // Subroutine at offset 0x60 leaves zero in T7 when shifts and XOR work
        prog[24] = rtype(FN_XOR, T0, S3, T5, 5'd0);
        prog[25] = rtype(FN_SLL, ZERO, S1, T6, 5'd4);
        prog[26] = rtype(FN_SRL, ZERO, T6, T6, 5'd4);
        prog[27] = rtype(FN_XOR, T6, S2, T7, 5'd0);
        prog[28] = rtype(FN_OR, T7, T5, T7, 5'd0);
        prog[29] = rtype(FN_JR, RA, ZERO, ZERO, 5'd0);
        prog[30] = rtype(FN_ADDU, V0, T7, V0, 5'd0);
    end

    // A request is seen on one edge before it can be accepted
    always @(posedge clk) begin
        if (reset) begin
            waitrequest <= 1'b1;
            readdata    <= '0;
        end else if ((read || write) && !waitrequest) begin
            waitrequest <= 1'b1;
            if (write && in_data) begin
                for (int b = 0; b < 4; b++) begin
                    if (byteenable[b]) begin
                        data[address[5:2]][8*b +: 8] <= writedata[8*b +: 8];
                    end
                end
            end
        end else if (read || write) begin
            waitrequest <= (($random(seed) & 3) == 0);
            readdata    <= in_prog ? prog[address[6:2]] :
                           in_data ? data[address[5:2]] : 32'h0;
        end else begin
            waitrequest <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: test/mips_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_tb
    import mips_core_pkg::*;
();

    localparam word_t    RESET_VECTOR = 32'hBFC00000;
    localparam word_t    DATA_ADDR    = 32'h00001000;
    localparam word_t    STORED_WORD  = 32'h12345678;
    // Both byte loads use offset 3
    localparam byte_en_t BYTE3_LANE   = 4'b1000;
    // SLT result, LBU byte, delay-slot count and LW word
    localparam word_t    EXPECTED_V0  = 32'd1 + 32'h12 + 32'd1 + STORED_WORD;
    // Up to 40 instructions with room for long stall runs on each
    localparam int       MAX_CYCLES   = 40 * 50;

    logic     clk;
    logic     reset;
    logic     waitrequest;
    logic     active;
    logic     read;
    logic     write;
    word_t    readdata;
    word_t    register_v0;
    word_t    address;
    word_t    writedata;
    byte_en_t byteenable;
    logic     data_access;

    int   errors;
    int   cycles;
    int   reads_done;
    int   writes_done;
    int   byte_reads;
    int   word_reads;
    logic started;
    logic halted_seen;

    assign data_access = (address >= DATA_ADDR) && (address < DATA_ADDR + 32'd64);

    mips_cpu_bus dut0 (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    avalon_memory mem0 (
        .clk(clk), .reset(reset), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .waitrequest(waitrequest),
        .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            cycles      <= 0;
            reads_done  <= 0;
            writes_done <= 0;
            byte_reads  <= 0;
            word_reads  <= 0;
            started     <= 1'b0;
            halted_seen <= 1'b0;
        end else begin
            cycles <= cycles + 1;
            if (active) begin
                started <= 1'b1;
            end
            if (started && !active) begin
                halted_seen <= 1'b1;
            end
            if (read && !waitrequest) begin
                reads_done <= reads_done + 1;
                if (data_access && byteenable != 4'hF) begin
                    byte_reads <= byte_reads + 1;
                end
                if (data_access && byteenable == 4'hF) begin
                    word_reads <= word_reads + 1;
                end
            end
            if (write && !waitrequest) begin
                writes_done <= writes_done + 1;
            end
        end
    end

    a_rw_exclusive: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            errors++;
            $display("read and write were high in the same cycle");
        end

    a_first_fetch_addr: assert property (@(posedge clk) disable iff (reset)
        read && !waitrequest && reads_done == 0 |-> address == RESET_VECTOR)
        else begin
            errors++;
            $display("mismatch address: got %h expected %h", address, RESET_VECTOR);
        end

    // Every instruction fetch, including those right after a byte load
    a_fetch_be: assert property (@(posedge clk) disable iff (reset)
        read && !waitrequest && !data_access |-> byteenable == 4'hF)
        else begin
            errors++;
            $display("mismatch byteenable: got %h expected %h", byteenable, 4'hF);
        end

    a_write_addr: assert property (@(posedge clk) disable iff (reset)
        write && !waitrequest |-> address == DATA_ADDR)
        else begin
            errors++;
            $display("mismatch address: got %h expected %h", address, DATA_ADDR);
        end

    a_write_be: assert property (@(posedge clk) disable iff (reset)
        write && !waitrequest |-> byteenable == 4'hF)
        else begin
            errors++;
            $display("mismatch byteenable: got %h expected %h", byteenable, 4'hF);
        end

    a_write_data: assert property (@(posedge clk) disable iff (reset)
        write && !waitrequest |-> writedata == STORED_WORD)
        else begin
            errors++;
            $display("mismatch writedata: got %h expected %h", writedata, STORED_WORD);
        end

    a_byte_lane: assert property (@(posedge clk) disable iff (reset)
        read && !waitrequest && data_access && byteenable != 4'hF |-> byteenable == BYTE3_LANE)
        else begin
            errors++;
            $display("mismatch byteenable: got %h expected %h", byteenable, BYTE3_LANE);
        end

    a_mapped: assert property (@(posedge clk) disable iff (reset)
        (read || write) && !waitrequest |-> data_access || mem0.in_prog)
        else begin
            errors++;
            $display("bus transfer outside the memory map at address %h", address);
        end

    a_final_v0: assert property (@(posedge clk) disable iff (reset)
        started && !active && !halted_seen |-> register_v0 == EXPECTED_V0)
        else begin
            errors++;
            $display("mismatch register_v0: got %h expected %h", register_v0, EXPECTED_V0);
        end

    a_idle_halted: assert property (@(posedge clk) disable iff (reset)
        started && !active |-> !read && !write)
        else begin
            errors++;
            $display("bus request raised after the CPU halted");
        end

    initial begin
        errors = 0;
        reset  = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        while (!halted_seen && cycles < MAX_CYCLES) begin
            @(posedge clk);
        end
        if (!halted_seen) begin
            errors++;
            $display("timeout, CPU still active after %0d cycles", MAX_CYCLES);
        end else begin
            // Idle bus after the halt
            repeat (5) @(posedge clk);
        end
        assert (writes_done == 1)
            else begin
                errors++;
                $display("expected one bus write, saw %0d", writes_done);
            end
        assert (byte_reads == 2 && word_reads == 1)
            else begin
                errors++;
                $display("saw %0d byte and %0d word data reads", byte_reads, word_reads);
            end
        assert (mem0.data[0] == STORED_WORD)
            else begin
                errors++;
                $display("mismatch data[0]: got %h expected %h", mem0.data[0], STORED_WORD);
            end
        $display("Checks done after %0d cycles, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/mips_isa_pkg.sv
hw/mips_core_pkg.sv
hw/cpu_control.sv
hw/register_file.sv
hw/alu_unit.sv
hw/load_store_unit.sv
hw/mips_cpu_bus.sv
test/avalon_memory.sv
test/mips_cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the MIPS CPU testbench with Verilator and runs it once
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module mips_cpu_tb -Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$BUILD_DIR/sim")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF "Test completed successfully"; then
    exit 0
fi
exit 1
